// ==== logic/lsu_pkg.sv ====
// load/store unit shared definitions

package lsu_pkg;

  // data path widths
  localparam int LSU_XLEN   = 64;
  localparam int LSU_NBYTES = 8;
  localparam int LSU_OFF_W  = 3;   // byte offset within a word

  // width of the operation code field
  // named apart from the signed word code below, which is LSU_OP_W
  localparam int LSU_OPC_W  = 3;

  // operation codes
  localparam logic [LSU_OPC_W-1:0] LSU_OP_B    = 3'd0;  // signed byte
  localparam logic [LSU_OPC_W-1:0] LSU_OP_BU   = 3'd1;  // unsigned byte
  localparam logic [LSU_OPC_W-1:0] LSU_OP_H    = 3'd2;  // signed half
  localparam logic [LSU_OPC_W-1:0] LSU_OP_HU   = 3'd3;  // unsigned half
  localparam logic [LSU_OPC_W-1:0] LSU_OP_W    = 3'd4;  // signed word
  localparam logic [LSU_OPC_W-1:0] LSU_OP_WU   = 3'd5;  // unsigned word
  localparam logic [LSU_OPC_W-1:0] LSU_OP_D    = 3'd6;  // doubleword
  localparam logic [LSU_OPC_W-1:0] LSU_OP_NONE = 3'd7;  // no access

  // local data memory
  localparam int LSU_RAM_WORDS = 256;
  localparam int LSU_IDX_W     = 8;   // word index, address bits 10:3

  // lane patterns at offset zero, one per access size
  localparam logic [LSU_NBYTES-1:0] LSU_LANES_B = 8'h01;
  localparam logic [LSU_NBYTES-1:0] LSU_LANES_H = 8'h03;
  localparam logic [LSU_NBYTES-1:0] LSU_LANES_W = 8'h0f;
  localparam logic [LSU_NBYTES-1:0] LSU_LANES_D = 8'hff;

endpackage

// ==== logic/lsu_req_stage.sv ====
// load/store request stage

`timescale 1ns/1ps

module lsu_req_stage (
  input  logic                            i_clk,
  input  logic                            i_arst_n,
  input  logic                            i_rd_en,
  input  logic                            i_wr_en,
  input  logic [lsu_pkg::LSU_OPC_W-1:0]   i_mem_op,
  input  logic [lsu_pkg::LSU_XLEN-1:0]    i_addr,
  input  logic [lsu_pkg::LSU_XLEN-1:0]    i_wdata,
  output logic                            o_wr_en,
  output logic                            o_rd_en,
  output logic                            o_ld_valid,
  output logic                            o_mis,
  output logic [lsu_pkg::LSU_IDX_W-1:0]   o_idx,
  output logic [lsu_pkg::LSU_NBYTES-1:0]  o_wmask,
  output logic [lsu_pkg::LSU_XLEN-1:0]    o_wdata,
  output logic [lsu_pkg::LSU_OFF_W-1:0]   o_off,
  output logic [lsu_pkg::LSU_OPC_W-1:0]   o_op
);

  logic [lsu_pkg::LSU_OFF_W-1:0]  off;
  logic [lsu_pkg::LSU_NBYTES-1:0] lanes;
  logic [lsu_pkg::LSU_OFF_W-1:0]  align_bits;  // offset bits that must be zero
  logic                           req_valid;
  logic                           mis;

  assign off       = i_addr[lsu_pkg::LSU_OFF_W-1:0];
  assign req_valid = (i_rd_en ^ i_wr_en) && (i_mem_op != lsu_pkg::LSU_OP_NONE);

  // access size from the op code
  always_comb begin
    case (i_mem_op)
      lsu_pkg::LSU_OP_B, lsu_pkg::LSU_OP_BU: begin
        lanes      = lsu_pkg::LSU_LANES_B;
        align_bits = 3'b000;
      end
      lsu_pkg::LSU_OP_H, lsu_pkg::LSU_OP_HU: begin
        lanes      = lsu_pkg::LSU_LANES_H;
        align_bits = 3'b001;
      end
      lsu_pkg::LSU_OP_W, lsu_pkg::LSU_OP_WU: begin
        lanes      = lsu_pkg::LSU_LANES_W;
        align_bits = 3'b011;
      end
      lsu_pkg::LSU_OP_D: begin
        lanes      = lsu_pkg::LSU_LANES_D;
        align_bits = 3'b111;
      end
      default: begin
        lanes      = '0;
        align_bits = 3'b000;
      end
    endcase
  end

  assign mis = |(off & align_bits);

  // control, cleared by reset
  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      o_wr_en    <= 1'b0;
      o_rd_en    <= 1'b0;
      o_ld_valid <= 1'b0;
      o_mis      <= 1'b0;
    end else begin
      o_wr_en    <= req_valid && i_wr_en && !mis;  // only aligned stores reach the ram
      o_rd_en    <= req_valid && i_rd_en && !mis;
      o_ld_valid <= req_valid && i_rd_en;
      o_mis      <= req_valid && mis;
    end
  end

  // payload
  always_ff @(posedge i_clk) begin
    o_idx   <= i_addr[lsu_pkg::LSU_OFF_W +: lsu_pkg::LSU_IDX_W];
    o_wmask <= lanes << off;
    o_wdata <= i_wdata << {off, 3'b000};  // low bytes moved to their lanes
    o_off   <= off;
    o_op    <= i_mem_op;
  end

  a_one_enable: assert property (@(posedge i_clk) disable iff (!i_arst_n)
    !(i_rd_en && i_wr_en));

endmodule

// ==== logic/lsu_data_ram.sv ====
// byte-masked data memory

`timescale 1ns/1ps

module lsu_data_ram (
  input  logic                            i_clk,
  input  logic                            i_arst_n,
  input  logic                            i_wr_en,
  input  logic                            i_rd_en,
  input  logic                            i_ld_valid,
  input  logic                            i_mis,
  input  logic [lsu_pkg::LSU_IDX_W-1:0]   i_idx,
  input  logic [lsu_pkg::LSU_NBYTES-1:0]  i_wmask,
  input  logic [lsu_pkg::LSU_XLEN-1:0]    i_wdata,
  input  logic [lsu_pkg::LSU_OFF_W-1:0]   i_off,
  input  logic [lsu_pkg::LSU_OPC_W-1:0]   i_op,
  output logic [lsu_pkg::LSU_XLEN-1:0]    o_rdata,
  output logic                            o_ld_valid,
  output logic                            o_mis,
  output logic [lsu_pkg::LSU_OFF_W-1:0]   o_off,
  output logic [lsu_pkg::LSU_OPC_W-1:0]   o_op
);

  logic [lsu_pkg::LSU_XLEN-1:0] mem [lsu_pkg::LSU_RAM_WORDS];

  // write enabled lanes, registered read
  always_ff @(posedge i_clk) begin
    if (i_wr_en) begin
      for (int b = 0; b < lsu_pkg::LSU_NBYTES; b++) begin
        if (i_wmask[b]) begin
          mem[i_idx][b*8 +: 8] <= i_wdata[b*8 +: 8];
        end
      end
    end
    if (i_rd_en) begin
      o_rdata <= mem[i_idx];
    end
    o_off <= i_off;
    o_op  <= i_op;
  end

  // load side information follows the read by one cycle
  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      o_ld_valid <= 1'b0;
      o_mis      <= 1'b0;
    end else begin
      o_ld_valid <= i_ld_valid;
      o_mis      <= i_mis;  // stores too, keeps the two-cycle flag latency
    end
  end

  a_mask_on_write: assert property (@(posedge i_clk) disable iff (!i_arst_n)
    i_wr_en |-> (i_wmask != '0));

endmodule

// ==== logic/lsu_resp_stage.sv ====
// load response stage

`timescale 1ns/1ps

module lsu_resp_stage (
  input  logic                            i_clk,
  input  logic                            i_arst_n,
  input  logic                            i_ld_valid,
  input  logic                            i_mis,
  input  logic [lsu_pkg::LSU_XLEN-1:0]    i_rdata,
  input  logic [lsu_pkg::LSU_OFF_W-1:0]   i_off,
  input  logic [lsu_pkg::LSU_OPC_W-1:0]   i_op,
  output logic [lsu_pkg::LSU_XLEN-1:0]    o_rdata,
  output logic                            o_rd_valid,
  output logic                            o_misaligned
);

  logic [lsu_pkg::LSU_XLEN-1:0] shifted;
  logic [lsu_pkg::LSU_XLEN-1:0] ext;

  // addressed bytes down to bit 0
  assign shifted = i_rdata >> {i_off, 3'b000};

  always_comb begin
    case (i_op)
      lsu_pkg::LSU_OP_B: begin
        ext = {{56{shifted[7]}}, shifted[7:0]};
      end
      lsu_pkg::LSU_OP_BU: begin
        ext = {56'd0, shifted[7:0]};
      end
      lsu_pkg::LSU_OP_H: begin
        ext = {{48{shifted[15]}}, shifted[15:0]};
      end
      lsu_pkg::LSU_OP_HU: begin
        ext = {48'd0, shifted[15:0]};
      end
      lsu_pkg::LSU_OP_W: begin
        ext = {{32{shifted[31]}}, shifted[31:0]};
      end
      lsu_pkg::LSU_OP_WU: begin
        ext = {32'd0, shifted[31:0]};
      end
      lsu_pkg::LSU_OP_D: begin
        ext = shifted;
      end
      default: begin
        ext = '0;
      end
    endcase
  end

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      o_rdata      <= '0;
      o_rd_valid   <= 1'b0;
      o_misaligned <= 1'b0;
    end else begin
      o_rd_valid   <= i_ld_valid;
      o_misaligned <= i_mis;
      if (i_ld_valid) begin
        o_rdata <= i_mis ? '0 : ext;  // ram word is stale on a misaligned load
      end
    end
  end

endmodule

// ==== logic/lsu_top.sv ====
// load/store unit top

`timescale 1ns/1ps

module lsu_top (
  input  logic                           i_clk,
  input  logic                           i_arst_n,
  input  logic                           i_rd_en,
  input  logic                           i_wr_en,
  input  logic [lsu_pkg::LSU_OPC_W-1:0]  i_mem_op,
  input  logic [lsu_pkg::LSU_XLEN-1:0]   i_addr,
  input  logic [lsu_pkg::LSU_XLEN-1:0]   i_wdata,
  output logic [lsu_pkg::LSU_XLEN-1:0]   o_rdata,
  output logic                           o_rd_valid,
  output logic                           o_misaligned
);

  // request stage outputs
  logic                           r_wr_en;
  logic                           r_rd_en;
  logic                           r_ld_valid;
  logic                           r_mis;
  logic [lsu_pkg::LSU_IDX_W-1:0]  r_idx;
  logic [lsu_pkg::LSU_NBYTES-1:0] r_wmask;
  logic [lsu_pkg::LSU_XLEN-1:0]   r_wdata;
  logic [lsu_pkg::LSU_OFF_W-1:0]  r_off;
  logic [lsu_pkg::LSU_OPC_W-1:0]  r_op;

  // memory stage outputs
  logic [lsu_pkg::LSU_XLEN-1:0]   m_rdata;
  logic                           m_ld_valid;
  logic                           m_mis;
  logic [lsu_pkg::LSU_OFF_W-1:0]  m_off;
  logic [lsu_pkg::LSU_OPC_W-1:0]  m_op;

  lsu_req_stage lsu_req_stage_i (
    .i_clk      (i_clk),      .i_arst_n  (i_arst_n),
    .i_rd_en    (i_rd_en),    .i_wr_en   (i_wr_en),
    .i_mem_op   (i_mem_op),   .i_addr    (i_addr),
    .i_wdata    (i_wdata),    .o_wr_en   (r_wr_en),
    .o_rd_en    (r_rd_en),    .o_ld_valid(r_ld_valid),
    .o_mis      (r_mis),      .o_idx     (r_idx),
    .o_wmask    (r_wmask),    .o_wdata   (r_wdata),
    .o_off      (r_off),      .o_op      (r_op)
  );

  lsu_data_ram lsu_data_ram_i (
    .i_clk      (i_clk),      .i_arst_n  (i_arst_n),
    .i_wr_en    (r_wr_en),    .i_rd_en   (r_rd_en),
    .i_ld_valid (r_ld_valid), .i_mis     (r_mis),
    .i_idx      (r_idx),      .i_wmask   (r_wmask),
    .i_wdata    (r_wdata),    .i_off     (r_off),
    .i_op       (r_op),       .o_rdata   (m_rdata),
    .o_ld_valid (m_ld_valid), .o_mis     (m_mis),
    .o_off      (m_off),      .o_op      (m_op)
  );

  lsu_resp_stage lsu_resp_stage_i (
    .i_clk        (i_clk),      .i_arst_n   (i_arst_n),
    .i_ld_valid   (m_ld_valid), .i_mis      (m_mis),
    .i_rdata      (m_rdata),    .i_off      (m_off),
    .i_op         (m_op),       .o_rdata    (o_rdata),
    .o_rd_valid   (o_rd_valid), .o_misaligned(o_misaligned)
  );

endmodule

// ==== verif/lsu_tb.sv ====
// load/store unit testbench

`timescale 1ns/1ps

module lsu_tb;

  localparam int N_FILL   = 32;   // words preloaded before random traffic
  localparam int N_RANDOM = 200;

  typedef struct packed {
    logic                           rd;
    logic                           wr;
    logic [lsu_pkg::LSU_OPC_W-1:0]  op;
    logic [lsu_pkg::LSU_XLEN-1:0]   addr;
    logic [lsu_pkg::LSU_XLEN-1:0]   wdata;
    logic [lsu_pkg::LSU_XLEN-1:0]   rdata;  // expected load data
    logic                           mis;    // expected misaligned flag
  } row_t;

  typedef struct packed {
    logic                           valid;
    logic                           mis;
    logic [lsu_pkg::LSU_XLEN-1:0]   rdata;
  } expect_t;

  logic                           i_clk;
  logic                           i_arst_n;
  logic                           i_rd_en;
  logic                           i_wr_en;
  logic [lsu_pkg::LSU_OPC_W-1:0]  i_mem_op;
  logic [lsu_pkg::LSU_XLEN-1:0]   i_addr;
  logic [lsu_pkg::LSU_XLEN-1:0]   i_wdata;
  logic [lsu_pkg::LSU_XLEN-1:0]   o_rdata;
  logic                           o_rd_valid;
  logic                           o_misaligned;

  row_t        table_q[$];
  expect_t     pend_q[$];      // results still in the pipeline
  logic [7:0]  model [2048];   // bytes by address bits 10:0
  logic [63:0] rng;
  int          cycles = 0;
  int          limit = 0;
  int          checked = 0;

  always #5 i_clk = ~i_clk;

  lsu_top lsu_top_i (
    .i_clk        (i_clk),
    .i_arst_n     (i_arst_n),
    .i_rd_en      (i_rd_en),
    .i_wr_en      (i_wr_en),
    .i_mem_op     (i_mem_op),
    .i_addr       (i_addr),
    .i_wdata      (i_wdata),
    .o_rdata      (o_rdata),
    .o_rd_valid   (o_rd_valid),
    .o_misaligned (o_misaligned)
  );

  function automatic logic [63:0] next_rand();
    rng = rng ^ (rng << 13);
    rng = rng ^ (rng >> 7);
    rng = rng ^ (rng << 17);
    return rng;
  endfunction

  function automatic int size_of(input logic [lsu_pkg::LSU_OPC_W-1:0] op);
    case (op)
      lsu_pkg::LSU_OP_B, lsu_pkg::LSU_OP_BU: return 1;
      lsu_pkg::LSU_OP_H, lsu_pkg::LSU_OP_HU: return 2;
      lsu_pkg::LSU_OP_W, lsu_pkg::LSU_OP_WU: return 4;
      default: return 8;
    endcase
  endfunction

  // little endian gather from the byte model, then extend
  function automatic logic [63:0] model_load(input logic [63:0] addr,
                                             input logic [lsu_pkg::LSU_OPC_W-1:0] op);
    logic [63:0] v;
    int          n;
    int          base;
    v    = '0;
    n    = size_of(op);
    base = int'(addr[10:0]);
    for (int j = 0; j < n; j++) begin
      v[8*j +: 8] = model[base + j];
    end
    if ((op == lsu_pkg::LSU_OP_B || op == lsu_pkg::LSU_OP_H || op == lsu_pkg::LSU_OP_W)
        && v[8*n-1]) begin
      for (int k = 8*n; k < 64; k++) begin
        v[k] = 1'b1;
      end
    end
    return v;
  endfunction

  task automatic compare_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
    if (got !== exp) begin
      $display("error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
      $display("TEST FAILED");
      $fatal(1, "output mismatch");
    end
  endtask

  task automatic check_result(input expect_t e);
    compare_value("o_rd_valid", 64'(o_rd_valid), 64'(e.valid));
    compare_value("o_misaligned", 64'(o_misaligned), 64'(e.mis));
    if (e.valid) begin
      compare_value("o_rdata", o_rdata, e.rdata);
    end
    checked++;
  endtask

  task automatic add_row(input logic rd, input logic wr,
                         input logic [lsu_pkg::LSU_OPC_W-1:0] op, input logic [63:0] addr,
                         input logic [63:0] wdata, input logic [63:0] rdata, input logic mis);
    table_q.push_back(row_t'{rd, wr, op, addr, wdata, rdata, mis});
  endtask

  // drive one request; the one driven three slots back is visible now
  task automatic apply_row(input row_t r);
    expect_t e;
    @(posedge i_clk);
    #1;
    if (pend_q.size() == 3) begin
      check_result(pend_q.pop_front());
    end
    i_rd_en  = r.rd;
    i_wr_en  = r.wr;
    i_mem_op = r.op;
    i_addr   = r.addr;
    i_wdata  = r.wdata;
    e.valid  = r.rd && !r.wr && (r.op != lsu_pkg::LSU_OP_NONE);
    e.mis    = r.mis;
    e.rdata  = r.rdata;
    pend_q.push_back(e);
  endtask

  task automatic build_table();
    // doubleword round trip, back to back and with a gap
    add_row(1'b0, 1'b1, lsu_pkg::LSU_OP_D,    64'h100, 64'h1122_3344_5566_7788, 64'h0, 1'b0);
    add_row(1'b1, 1'b0, lsu_pkg::LSU_OP_D,    64'h100, 64'h0, 64'h1122_3344_5566_7788, 1'b0);
    add_row(1'b0, 1'b1, lsu_pkg::LSU_OP_D,    64'h108, 64'hdead_beef_cafe_f00d, 64'h0, 1'b0);
    add_row(1'b0, 1'b0, lsu_pkg::LSU_OP_D,    64'h108, 64'h0, 64'h0, 1'b0);
    add_row(1'b1, 1'b0, lsu_pkg::LSU_OP_D,    64'hffff_0000_0000_0108, 64'h0,
            64'hdead_beef_cafe_f00d, 1'b0);  // upper address bits ignored
    // byte lanes, every offset
    add_row(1'b0, 1'b1, lsu_pkg::LSU_OP_D,    64'h200, 64'haaaa_aaaa_aaaa_aaaa, 64'h0, 1'b0);
    add_row(1'b0, 1'b1, lsu_pkg::LSU_OP_B,    64'h200, 64'hffff_ffff_ffff_ff10, 64'h0, 1'b0);
    add_row(1'b0, 1'b1, lsu_pkg::LSU_OP_BU,   64'h202, 64'hffff_ffff_ffff_ff12, 64'h0, 1'b0);
    add_row(1'b0, 1'b1, lsu_pkg::LSU_OP_B,    64'h205, 64'hffff_ffff_ffff_ff15, 64'h0, 1'b0);
    add_row(1'b0, 1'b1, lsu_pkg::LSU_OP_BU,   64'h207, 64'hffff_ffff_ffff_ff17, 64'h0, 1'b0);
    add_row(1'b1, 1'b0, lsu_pkg::LSU_OP_D,    64'h200, 64'h0, 64'h17aa_15aa_aa12_aa10, 1'b0);
    add_row(1'b0, 1'b1, lsu_pkg::LSU_OP_BU,   64'h201, 64'hffff_ffff_ffff_ff11, 64'h0, 1'b0);
    add_row(1'b0, 1'b1, lsu_pkg::LSU_OP_B,    64'h203, 64'hffff_ffff_ffff_ff13, 64'h0, 1'b0);
    add_row(1'b0, 1'b1, lsu_pkg::LSU_OP_BU,   64'h204, 64'hffff_ffff_ffff_ff14, 64'h0, 1'b0);
    add_row(1'b0, 1'b1, lsu_pkg::LSU_OP_B,    64'h206, 64'hffff_ffff_ffff_ff16, 64'h0, 1'b0);
    add_row(1'b1, 1'b0, lsu_pkg::LSU_OP_D,    64'h200, 64'h0, 64'h1716_1514_1312_1110, 1'b0);
    // half lanes
    add_row(1'b0, 1'b1, lsu_pkg::LSU_OP_D,    64'h208, 64'hffff_ffff_ffff_ffff, 64'h0, 1'b0);
    add_row(1'b0, 1'b1, lsu_pkg::LSU_OP_H,    64'h208, 64'h9999_9999_9999_1234, 64'h0, 1'b0);
    add_row(1'b0, 1'b1, lsu_pkg::LSU_OP_HU,   64'h20c, 64'h9999_9999_9999_5678, 64'h0, 1'b0);
    add_row(1'b1, 1'b0, lsu_pkg::LSU_OP_D,    64'h208, 64'h0, 64'hffff_5678_ffff_1234, 1'b0);
    add_row(1'b0, 1'b1, lsu_pkg::LSU_OP_H,    64'h20a, 64'h9999_9999_9999_abcd, 64'h0, 1'b0);
    add_row(1'b0, 1'b1, lsu_pkg::LSU_OP_HU,   64'h20e, 64'h9999_9999_9999_ef01, 64'h0, 1'b0);
    add_row(1'b1, 1'b0, lsu_pkg::LSU_OP_D,    64'h208, 64'h0, 64'hef01_5678_abcd_1234, 1'b0);
    // sign and zero extension of the same bytes
    add_row(1'b0, 1'b1, lsu_pkg::LSU_OP_D,    64'h218, 64'hc3d4_e5f6_8899_aab7, 64'h0, 1'b0);
    add_row(1'b1, 1'b0, lsu_pkg::LSU_OP_B,    64'h21d, 64'h0, 64'hffff_ffff_ffff_ffe5, 1'b0);
    add_row(1'b1, 1'b0, lsu_pkg::LSU_OP_BU,   64'h21d, 64'h0, 64'h0000_0000_0000_00e5, 1'b0);
    add_row(1'b1, 1'b0, lsu_pkg::LSU_OP_H,    64'h21e, 64'h0, 64'hffff_ffff_ffff_c3d4, 1'b0);
    add_row(1'b1, 1'b0, lsu_pkg::LSU_OP_HU,   64'h21e, 64'h0, 64'h0000_0000_0000_c3d4, 1'b0);
    add_row(1'b1, 1'b0, lsu_pkg::LSU_OP_W,    64'h21c, 64'h0, 64'hffff_ffff_c3d4_e5f6, 1'b0);
    add_row(1'b1, 1'b0, lsu_pkg::LSU_OP_WU,   64'h21c, 64'h0, 64'h0000_0000_c3d4_e5f6, 1'b0);
    // misaligned, nothing written and zero data
    add_row(1'b0, 1'b1, lsu_pkg::LSU_OP_H,    64'h219, 64'hffff_ffff_ffff_ffff, 64'h0, 1'b1);
    add_row(1'b0, 1'b1, lsu_pkg::LSU_OP_W,    64'h21a, 64'hffff_ffff_ffff_ffff, 64'h0, 1'b1);
    add_row(1'b0, 1'b1, lsu_pkg::LSU_OP_D,    64'h21c, 64'hffff_ffff_ffff_ffff, 64'h0, 1'b1);
    add_row(1'b1, 1'b0, lsu_pkg::LSU_OP_HU,   64'h21b, 64'h0, 64'h0, 1'b1);
    add_row(1'b1, 1'b0, lsu_pkg::LSU_OP_D,    64'h21c, 64'h0, 64'h0, 1'b1);
    add_row(1'b1, 1'b0, lsu_pkg::LSU_OP_D,    64'h218, 64'h0, 64'hc3d4_e5f6_8899_aab7, 1'b0);
    // no access
    add_row(1'b1, 1'b0, lsu_pkg::LSU_OP_NONE, 64'h218, 64'h0, 64'h0, 1'b0);
    add_row(1'b0, 1'b1, lsu_pkg::LSU_OP_NONE, 64'h218, 64'h0, 64'h0, 1'b0);
    add_row(1'b0, 1'b0, lsu_pkg::LSU_OP_D,    64'h219, 64'h0, 64'h0, 1'b0);
    add_row(1'b1, 1'b0, lsu_pkg::LSU_OP_D,    64'h218, 64'h0, 64'hc3d4_e5f6_8899_aab7, 1'b0);
  endtask

  // fill words 0 to N_FILL-1 so random loads never see unwritten bytes
  task automatic preload_random_region();
    logic [63:0] addr;
    logic [63:0] wdata;
    for (int w = 0; w < N_FILL; w++) begin
      addr  = 64'(w * 8);
      wdata = 64'h9e37_79b9_7f4a_7c15 * (addr + 64'd1);
      for (int j = 0; j < 8; j++) begin
        model[w*8 + j] = wdata[8*j +: 8];
      end
      apply_row(row_t'{1'b0, 1'b1, lsu_pkg::LSU_OP_D, addr, wdata, 64'h0, 1'b0});
    end
  endtask

  task automatic run_random_op();
    row_t        r;
    logic [63:0] r1;
    logic [63:0] r2;
    int          n;
    int          base;
    r1      = next_rand();
    r2      = next_rand();
    r.op    = (r1[2:0] == lsu_pkg::LSU_OP_NONE) ? lsu_pkg::LSU_OP_D : r1[2:0];
    r.rd    = r1[3];
    r.wr    = !r1[3];
    r.addr  = {r2[63:11], 3'b000, r2[7:0]};  // words 0 to 31
    n       = size_of(r.op);
    if (r1[5:4] != 2'b00) begin
      r.addr[2:0] = r.addr[2:0] & ~3'(n - 1);  // mostly aligned
    end
    r.wdata = next_rand();
    r.mis   = (r.addr[2:0] & 3'(n - 1)) != 3'b000;
    r.rdata = '0;
    base    = int'(r.addr[10:0]);
    if (r.wr && !r.mis) begin
      for (int j = 0; j < n; j++) begin
        model[base + j] = r.wdata[8*j +: 8];
      end
    end
    if (r.rd && !r.mis) begin
      r.rdata = model_load(r.addr, r.op);
    end
    apply_row(r);
  endtask

  always @(posedge i_clk) begin
    cycles++;
    if (cycles > limit) begin
      $display("timeout: the run did not finish within %0d cycles", limit);
      $display("TEST FAILED");
      $fatal(1, "timeout");
    end
  end

  initial begin
    i_clk    = 1'b0;
    i_arst_n = 1'b0;
    i_rd_en  = 1'b0;
    i_wr_en  = 1'b0;
    i_mem_op = lsu_pkg::LSU_OP_NONE;
    i_addr   = '0;
    i_wdata  = '0;
    rng      = 64'd77141;
    build_table();
    limit = 2 * (table_q.size() + N_FILL + N_RANDOM) + 50;
    repeat (8) @(posedge i_clk);
    #1;
    i_arst_n = 1'b1;
    foreach (table_q[i]) begin
      apply_row(table_q[i]);
    end
    preload_random_region();
    repeat (N_RANDOM) run_random_op();
    repeat (3) apply_row(row_t'{1'b0, 1'b0, lsu_pkg::LSU_OP_NONE, 64'h0, 64'h0, 64'h0, 1'b0});
    if (checked == table_q.size() + N_FILL + N_RANDOM) begin
      $display("TEST PASSED");
      $finish;
    end else begin
      $display("only %0d requests had their results checked", checked);
      $display("TEST FAILED");
      $fatal(1, "incomplete run");
    end
  end

endmodule

// ==== verilog.f ====
logic/lsu_pkg.sv
logic/lsu_req_stage.sv
logic/lsu_data_ram.sv
logic/lsu_resp_stage.sv
logic/lsu_top.sv
verif/lsu_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the load/store unit testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module lsu_tb -f verilog.f -o lsu_sim

# the simulator status is not trusted alone; the log decides
./obj_dir/lsu_sim > sim.log 2>&1 || true
cat sim.log

grep -q "TEST PASSED" sim.log
echo "simulation passed"
